//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)
	! grep -q "Result: FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
hw/udp_gen_pkg.sv
hw/udp_cfg_regs.sv
hw/ip_checksum.sv
hw/udp_frame_words.sv
hw/udp_tx_sched.sv
hw/udp_stream_top.sv
test/tb_clock.sv
test/udp_assertions.sv
test/tb_top.sv

//--- hw/ip_checksum.sv
module ip_checksum import udp_gen_pkg::*; (
    input  logic     m00_axis_aclk,
    input  logic     m00_axis_aresetn,
    input  net_cfg_t net_cfg,
    output hdr_cfg_t hdr_cfg
);

    ipv4_t       src_be;
    ipv4_t       dst_be;
    logic [19:0] sum;    // Ten 16-bit words never exceed 20 bits
    logic [16:0] fold1;
    logic [15:0] fold2;

    assign src_be = ip_be(net_cfg.src_ip);
    assign dst_be = ip_be(net_cfg.dst_ip);

    // Checksum field itself counts as zero
    assign sum = 20'(ip_ver_ihl) + 20'(ip_total_len) + 20'(ip_ident) + 20'(ip_flags)
               + 20'({ip_ttl, ip_proto})
               + 20'(src_be[31:16]) + 20'(src_be[15:0])
               + 20'(dst_be[31:16]) + 20'(dst_be[15:0]);

    // End-around carry
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);  // Cannot carry again

    // Addresses and their checksum move together
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            hdr_cfg <= '0;
        end else begin
            hdr_cfg.net  <= net_cfg;
            hdr_cfg.csum <= ~fold2;
        end
    end

endmodule

//--- hw/udp_cfg_regs.sv
module udp_cfg_regs import udp_gen_pkg::*; #(
    parameter reg_data_t DEFAULT_DELAY   = 32'd10_000_000,
    parameter mac_t      DEFAULT_DST_MAC = 48'hFFFF_FFFF_FFFF,
    parameter ipv4_t     DEFAULT_SRC_IP  = 32'h6304_A8C0,  // 192.168.4.99
    parameter ipv4_t     DEFAULT_DST_IP  = 32'h0104_A8C0   // 192.168.4.1
) (
    input  logic      m00_axis_aclk,
    input  logic      m00_axis_aresetn,
    input  reg_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  reg_data_t wdata,
    input  logic      wvalid,
    output logic      wready,
    output logic      bvalid,
    input  logic      bready,
    input  reg_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output reg_data_t rdata,
    output logic      rvalid,
    input  logic      rready,
    input  reg_data_t sent_count,
    output reg_data_t delay,
    output net_cfg_t  net_cfg
);

    logic wr_en;
    logic rd_en;

    // One write and one read outstanding at most
    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign arready = !rvalid;

    assign wr_en = awvalid && wvalid && !bvalid;
    assign rd_en = arvalid && !rvalid;

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            delay   <= DEFAULT_DELAY;
            net_cfg <= '{dst_mac: DEFAULT_DST_MAC, src_ip: DEFAULT_SRC_IP,
                         dst_ip: DEFAULT_DST_IP};
        end else if (wr_en) begin
            case (awaddr)
                reg_delay:   delay                 <= wdata;
                reg_dmac_lo: net_cfg.dst_mac[47:16] <= wdata;
                reg_dmac_hi: net_cfg.dst_mac[15:0]  <= wdata[15:0];
                reg_src_ip:  net_cfg.src_ip        <= wdata;
                reg_dst_ip:  net_cfg.dst_ip        <= wdata;
                default: ;  // Read-only or unmapped
            endcase
        end
    end

    // Write response
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read data captured with the address, held until rready
    always_ff @(posedge m00_axis_aclk) begin
        if (rd_en) begin
            case (araddr)
                reg_sent:    rdata <= sent_count;
                reg_delay:   rdata <= delay;
                reg_dmac_lo: rdata <= net_cfg.dst_mac[47:16];
                reg_dmac_hi: rdata <= {16'h0000, net_cfg.dst_mac[15:0]};
                reg_src_ip:  rdata <= net_cfg.src_ip;
                reg_dst_ip:  rdata <= net_cfg.dst_ip;
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

//--- hw/udp_frame_words.sv
module udp_frame_words import udp_gen_pkg::*; (
    input  beat_idx_t beat_idx,
    input  hdr_cfg_t  hdr,
    output word_t     data_word
);

    // Header bytes in wire order, element 0 goes out first
    logic [0:hdr_len-1][7:0] hdr_b;

    assign hdr_b = {
        // Ethernet
        hdr.net.dst_mac[7:0],   hdr.net.dst_mac[15:8],  hdr.net.dst_mac[23:16],
        hdr.net.dst_mac[31:24], hdr.net.dst_mac[39:32], hdr.net.dst_mac[47:40],
        src_mac,
        ether_type,
        // IPv4
        ip_ver_ihl,
        ip_total_len,
        ip_ident,
        ip_flags,
        ip_ttl,
        ip_proto,
        hdr.csum,
        ip_be(hdr.net.src_ip),
        ip_be(hdr.net.dst_ip),
        // UDP, checksum unused
        udp_port,
        udp_port,
        udp_len,
        16'h0000
    };

    // Byte n of the frame lands in lane n mod 8 of beat n / 8
    always_comb begin
        logic [7:0]  n;
        logic [7:0]  p;
        logic [15:0] pay_short;

        for (int lane = 0; lane < 8; lane++) begin
            n = {beat_idx, 3'(lane)};
            p = n - 8'(hdr_len);  // Offset into the payload

            // Short 2k is k, short 2k+1 is 255-k
            pay_short = p[1] ? 16'(8'd255 - 8'(p[7:2])) : 16'(p[7:2]);

            if (n < 8'(hdr_len)) begin
                data_word[8*lane +: 8] = hdr_b[n];
            end else if (n < 8'(frame_bytes)) begin
                data_word[8*lane +: 8] = p[0] ? pay_short[15:8] : pay_short[7:0];
            end else begin
                data_word[8*lane +: 8] = 8'h00;  // Past the end of the frame
            end
        end
    end

endmodule

//--- hw/udp_gen_pkg.sv
package udp_gen_pkg;

    // Widths with a meaning of their own
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0]  keep_t;
    typedef logic [4:0]  beat_idx_t;  // Beat 0 to 21
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] csum_t;

    // Addresses kept in wire order, first byte in bits 7:0
    typedef struct packed {
        mac_t  dst_mac;
        ipv4_t src_ip;
        ipv4_t dst_ip;
    } net_cfg_t;

    typedef struct packed {
        net_cfg_t net;
        csum_t    csum;  // Header checksum as sent, big-endian value
    } hdr_cfg_t;

    typedef struct packed {
        word_t tdata;
        keep_t tkeep;
        logic  tlast;
    } axis_beat_t;

    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_t;

    // Register map, byte offsets
    localparam reg_addr_t reg_sent    = 5'h00;
    localparam reg_addr_t reg_delay   = 5'h08;
    localparam reg_addr_t reg_dmac_lo = 5'h0C;  // Wire bytes 2 to 5
    localparam reg_addr_t reg_dmac_hi = 5'h10;  // Wire bytes 0 and 1
    localparam reg_addr_t reg_src_ip  = 5'h14;
    localparam reg_addr_t reg_dst_ip  = 5'h18;

    // Fixed header fields, most significant byte goes out first
    localparam mac_t        src_mac      = 48'h001A_2B3C_4D5E;
    localparam logic [15:0] ether_type   = 16'h0800;
    localparam logic [15:0] ip_ver_ihl   = 16'h4500;  // Version 4, IHL 5, TOS 0
    localparam logic [15:0] ip_total_len = 16'd156;
    localparam logic [15:0] ip_ident     = 16'd1;
    localparam logic [15:0] ip_flags     = 16'h4000;  // Don't fragment
    localparam logic [7:0]  ip_ttl       = 8'd255;
    localparam logic [7:0]  ip_proto     = 8'd17;     // UDP
    localparam logic [15:0] udp_port     = 16'd60133;
    localparam logic [15:0] udp_len      = 16'd136;

    // Frame geometry
    localparam int    hdr_len     = 42;  // Ethernet + IP + UDP
    localparam int    frame_bytes = 170;
    localparam int    frame_beats = 22;
    localparam keep_t last_keep   = 8'h03;

    // Wire-order address to its big-endian value
    function automatic ipv4_t ip_be(ipv4_t a);
        return {a[7:0], a[15:8], a[23:16], a[31:24]};
    endfunction

endpackage

//--- hw/udp_stream_top.sv
module udp_stream_top import udp_gen_pkg::*; #(
    parameter reg_data_t DEFAULT_DELAY   = 32'd10_000_000,
    parameter mac_t      DEFAULT_DST_MAC = 48'hFFFF_FFFF_FFFF,
    parameter ipv4_t     DEFAULT_SRC_IP  = 32'h6304_A8C0,  // 192.168.4.99
    parameter ipv4_t     DEFAULT_DST_IP  = 32'h0104_A8C0   // 192.168.4.1
) (
    input  logic      m00_axis_aclk,
    input  logic      m00_axis_aresetn,
    input  reg_addr_t s00_axi_awaddr,
    input  logic      s00_axi_awvalid,
    output logic      s00_axi_awready,
    input  reg_data_t s00_axi_wdata,
    input  logic      s00_axi_wvalid,
    output logic      s00_axi_wready,
    output logic      s00_axi_bvalid,
    input  logic      s00_axi_bready,
    input  reg_addr_t s00_axi_araddr,
    input  logic      s00_axi_arvalid,
    output logic      s00_axi_arready,
    output reg_data_t s00_axi_rdata,
    output logic      s00_axi_rvalid,
    input  logic      s00_axi_rready,
    output logic      m00_axis_tvalid,
    output word_t     m00_axis_tdata,
    output keep_t     m00_axis_tkeep,
    output logic      m00_axis_tlast,
    input  logic      m00_axis_tready
);

    reg_data_t  sent_count;
    reg_data_t  delay;
    net_cfg_t   net_cfg;
    hdr_cfg_t   hdr_cfg;
    hdr_cfg_t   hdr_snap;
    beat_idx_t  beat_idx;
    word_t      data_word;
    axis_beat_t beat;

    udp_cfg_regs #(
        .DEFAULT_DELAY  (DEFAULT_DELAY),
        .DEFAULT_DST_MAC(DEFAULT_DST_MAC),
        .DEFAULT_SRC_IP (DEFAULT_SRC_IP),
        .DEFAULT_DST_IP (DEFAULT_DST_IP)
    ) regs0 (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .awaddr          (s00_axi_awaddr),
        .awvalid         (s00_axi_awvalid),
        .awready         (s00_axi_awready),
        .wdata           (s00_axi_wdata),
        .wvalid          (s00_axi_wvalid),
        .wready          (s00_axi_wready),
        .bvalid          (s00_axi_bvalid),
        .bready          (s00_axi_bready),
        .araddr          (s00_axi_araddr),
        .arvalid         (s00_axi_arvalid),
        .arready         (s00_axi_arready),
        .rdata           (s00_axi_rdata),
        .rvalid          (s00_axi_rvalid),
        .rready          (s00_axi_rready),
        .sent_count      (sent_count),
        .delay           (delay),
        .net_cfg         (net_cfg)
    );

    ip_checksum csum0 (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .net_cfg         (net_cfg),
        .hdr_cfg         (hdr_cfg)
    );

    udp_tx_sched sched0 (
        .m00_axis_aclk   (m00_axis_aclk),
        .m00_axis_aresetn(m00_axis_aresetn),
        .delay           (delay),
        .hdr_cfg         (hdr_cfg),
        .beat_idx        (beat_idx),
        .hdr_snap        (hdr_snap),
        .data_word       (data_word),
        .tready          (m00_axis_tready),
        .tvalid          (m00_axis_tvalid),
        .beat            (beat),
        .sent_count      (sent_count)
    );

    udp_frame_words words0 (
        .beat_idx (beat_idx),
        .hdr      (hdr_snap),
        .data_word(data_word)
    );

    // Stream beat onto the master port
    assign m00_axis_tdata = beat.tdata;
    assign m00_axis_tkeep = beat.tkeep;
    assign m00_axis_tlast = beat.tlast;

endmodule

//--- hw/udp_tx_sched.sv
module udp_tx_sched import udp_gen_pkg::*; (
    input  logic       m00_axis_aclk,
    input  logic       m00_axis_aresetn,
    input  reg_data_t  delay,
    input  hdr_cfg_t   hdr_cfg,
    output beat_idx_t  beat_idx,
    output hdr_cfg_t   hdr_snap,
    input  word_t      data_word,
    input  logic       tready,
    output logic       tvalid,
    output axis_beat_t beat,
    output reg_data_t  sent_count
);

    localparam beat_idx_t last_beat = beat_idx_t'(frame_beats - 1);

    reg_data_t timer;
    logic      trigger;
    logic      last;
    tx_state_t state;

    assign trigger = (delay != '0) && (timer == delay);

    // Interval timer
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            timer <= '0;
        end else if (delay == '0 || trigger) begin
            timer <= '0;  // Stopped, or wrapped
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // Beat FSM, a trigger during a packet is lost
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            state      <= tx_idle;
            beat_idx   <= '0;
            sent_count <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (trigger) begin
                        state    <= tx_send;
                        beat_idx <= '0;
                    end
                end
                tx_send: begin
                    if (tready) begin
                        if (beat_idx == last_beat) begin
                            state      <= tx_idle;
                            sent_count <= sent_count + 1'b1;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // Header frozen for the whole packet
    always_ff @(posedge m00_axis_aclk) begin
        if (state == tx_idle && trigger) begin
            hdr_snap <= hdr_cfg;
        end
    end

    assign tvalid = (state == tx_send);
    assign last   = tvalid && (beat_idx == last_beat);

    assign beat.tdata = data_word;
    assign beat.tkeep = last ? last_keep : 8'hFF;  // Two bytes left in the final beat
    assign beat.tlast = last;

endmodule

//--- test/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release reset just after an edge, away from the sampling point
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

//--- test/tb_top.sv
module tb_top;

    localparam int DELAY = 200;
    localparam int BEATS = 22;

    logic        clk;
    logic        rstn;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic        tvalid;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tlast;
    logic        tready;

    byte         ops[$];
    int unsigned addrs[$];
    int unsigned datas[$];
    bit          loaded = 1'b0;
    logic [31:0] dmac_lo = 32'hFFFF_FFFF;  // Register image of the addressing
    logic [31:0] dmac_hi = 32'h0000_FFFF;
    logic [31:0] src_ip  = 32'h6304_A8C0;
    logic [31:0] dst_ip  = 32'h0104_A8C0;
    logic [7:0]  exp_b [0:BEATS*8-1];
    logic [15:0] lfsr = 16'h0001;
    int          case_err;
    int          fails = 0;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(8)) clk0 (.clk(clk), .rstn(rstn));

    udp_stream_top #(.DEFAULT_DELAY(32'(DELAY))) dut0 (
        .m00_axis_aclk(clk), .m00_axis_aresetn(rstn),
        .s00_axi_awaddr(awaddr), .s00_axi_awvalid(awvalid), .s00_axi_awready(awready),
        .s00_axi_wdata(wdata), .s00_axi_wvalid(wvalid), .s00_axi_wready(wready),
        .s00_axi_bvalid(bvalid), .s00_axi_bready(bready),
        .s00_axi_araddr(araddr), .s00_axi_arvalid(arvalid), .s00_axi_arready(arready),
        .s00_axi_rdata(rdata), .s00_axi_rvalid(rvalid), .s00_axi_rready(rready),
        .m00_axis_tvalid(tvalid), .m00_axis_tdata(tdata), .m00_axis_tkeep(tkeep),
        .m00_axis_tlast(tlast), .m00_axis_tready(tready)
    );

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        byte   op;
        int unsigned a;
        int unsigned d;

        fd = $fopen("test/udp_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/udp_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] != 8'h23) begin  // Skip comments
                    n = $sscanf(line, "%c %h %h", op, a, d);
                    if (n == 3) begin
                        ops.push_back(op);
                        addrs.push_back(a);
                        datas.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_reg(logic [4:0] a, logic [31:0] d);
        logic rdy;

        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        rdy     = 1'b0;
        while (!rdy) begin
            rdy = awready && wready;
            @(posedge clk);
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (bvalid) begin
            @(posedge clk);
            #1;
        end
        bready = 1'b0;
        case (a)  // Keep the expected image in step
            5'h0C: dmac_lo = d;
            5'h10: dmac_hi = {16'h0000, d[15:0]};
            5'h14: src_ip  = d;
            5'h18: dst_ip  = d;
            default: ;
        endcase
        repeat (3) @(posedge clk);  // Let the checksum settle
        #1;
    endtask

    task automatic read_reg(logic [4:0] a, logic [31:0] expected);
        logic rdy;

        araddr  = a;
        arvalid = 1'b1;
        rdy     = 1'b0;
        while (!rdy) begin
            rdy = arready;
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge clk);
            #1;
        end
        assert (rdata == expected) else begin
            $display("[ERROR] rdata @%02h: got %08h, expected %08h", a, rdata, expected);
            case_err++;
        end
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Expected frame straight from the byte layout
    task automatic build_frame();
        logic [31:0] sum;
        logic [15:0] v;

        for (int i = 0; i < BEATS * 8; i++) exp_b[i] = 8'h00;
        exp_b[0] = dmac_hi[7:0];
        exp_b[1] = dmac_hi[15:8];
        for (int i = 0; i < 4; i++) begin
            exp_b[2 + i]  = dmac_lo[8*i +: 8];
            exp_b[26 + i] = src_ip[8*i +: 8];
            exp_b[30 + i] = dst_ip[8*i +: 8];
        end
        {exp_b[6], exp_b[7], exp_b[8]}   = 24'h001A2B;
        {exp_b[9], exp_b[10], exp_b[11]} = 24'h3C4D5E;
        {exp_b[12], exp_b[13]} = 16'h0800;
        {exp_b[14], exp_b[15]} = 16'h4500;
        {exp_b[16], exp_b[17]} = 16'd156;
        {exp_b[18], exp_b[19]} = 16'd1;
        {exp_b[20], exp_b[21]} = 16'h4000;
        {exp_b[22], exp_b[23]} = {8'd255, 8'd17};
        {exp_b[34], exp_b[35]} = 16'd60133;
        {exp_b[36], exp_b[37]} = 16'd60133;
        {exp_b[38], exp_b[39]} = 16'd136;
        sum = 32'h0;
        for (int i = 14; i < 34; i += 2) sum += {16'h0000, exp_b[i], exp_b[i + 1]};
        while (sum[31:16] != 16'h0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        {exp_b[24], exp_b[25]} = ~sum[15:0];
        for (int j = 0; j < 64; j++) begin
            v = (j % 2 == 0) ? 16'(j / 2) : 16'(255 - j / 2);
            exp_b[42 + 2*j] = v[7:0];
            exp_b[43 + 2*j] = v[15:8];
        end
    endtask

    task automatic capture_frame();
        logic [63:0] got_d [0:BEATS-1];
        logic [7:0]  got_k [0:BEATS-1];
        logic        got_l [0:BEATS-1];
        logic [63:0] exp_d;
        logic [7:0]  exp_k;
        logic        exp_l;
        logic [63:0] d;
        logic [7:0]  k;
        logic        l;
        logic        v;
        logic        r;
        int          got;

        build_frame();
        got = 0;
        v   = 1'b0;
        r   = 1'b0;
        while (got < BEATS) begin
            if (v && r) begin  // Transfer at the edge just passed
                got_d[got] = d;
                got_k[got] = k;
                got_l[got] = l;
                got++;
            end
            if (got < BEATS) begin
                v      = tvalid;
                d      = tdata;
                k      = tkeep;
                l      = tlast;
                lfsr   = lfsr_step(lfsr);
                r      = lfsr[0];
                tready = r;
                @(posedge clk);
                #1;
            end
        end
        tready = 1'b0;
        for (int i = 0; i < BEATS; i++) begin
            for (int b = 0; b < 8; b++) exp_d[8*b +: 8] = exp_b[8*i + b];
            exp_k = (i == BEATS - 1) ? 8'h03 : 8'hFF;
            exp_l = (i == BEATS - 1);
            assert (got_d[i] == exp_d) else begin
                $display("[ERROR] tdata beat %0d: got %016h, expected %016h", i, got_d[i], exp_d);
                case_err++;
            end
            assert (got_k[i] == exp_k) else begin
                $display("[ERROR] tkeep beat %0d: got %02h, expected %02h", i, got_k[i], exp_k);
                case_err++;
            end
            assert (got_l[i] == exp_l) else begin
                $display("[ERROR] tlast beat %0d: got %0h, expected %0h", i, got_l[i], exp_l);
                case_err++;
            end
        end
    endtask

    task automatic idle_check(int cycles);
        int seen;

        seen = 0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (tvalid) seen++;
        end
        assert (seen == 0) else begin
            $display("a packet started although the timer was stopped (%0d cycles)", seen);
            case_err++;
        end
    endtask

    // Watchdog sized from the number of cases
    initial begin
        wait (loaded);
        #(longint'(ops.size()) * (DELAY + 40) * 8);
        $display("watchdog expired, the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        tready  = 1'b0;
        load_cases();
        if (ops.size() == 0) begin
            $display("no cases to run");
            $display("Result: FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (rstn);
            @(posedge clk);
            #1;
            foreach (ops[i]) begin
                case_err = 0;
                case (ops[i])
                    "W": write_reg(5'(addrs[i]), datas[i]);
                    "R": read_reg(5'(addrs[i]), datas[i]);
                    "C": capture_frame();
                    "I": idle_check(int'(datas[i]));
                    default: begin
                        $display("unknown operation in case %0d", i);
                        case_err++;
                    end
                endcase
                if (case_err != 0) fails++;
                $display("case %0d %c %02h: %s", i, ops[i], addrs[i],
                         (case_err == 0) ? "ok" : "bad");
            end
            $display("%0d cases run, %0d failed", ops.size(), fails);
            if (fails == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

//--- test/udp_assertions.sv
module udp_assertions (
    input logic        m00_axis_aclk,
    input logic        m00_axis_aresetn,
    input logic        m00_axis_tvalid,
    input logic [63:0] m00_axis_tdata,
    input logic [7:0]  m00_axis_tkeep,
    input logic        m00_axis_tlast,
    input logic        m00_axis_tready
);

    // A stalled beat must not change
    hold_beat: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tvalid && !m00_axis_tready |=> m00_axis_tvalid && $stable(m00_axis_tdata)
        && $stable(m00_axis_tkeep) && $stable(m00_axis_tlast))
        else $error("stream beat changed under back-pressure");

    keep_last: assert property (@(posedge m00_axis_aclk) disable iff (!m00_axis_aresetn)
        m00_axis_tvalid |-> (m00_axis_tlast == (m00_axis_tkeep == 8'h03)))
        else $error("tkeep and tlast disagree");

    quiet_reset: assert property (@(posedge m00_axis_aclk) !m00_axis_aresetn |-> !m00_axis_tvalid)
        else $error("tvalid high during reset");

endmodule

bind udp_stream_top udp_assertions chk0 (
    .m00_axis_aclk   (m00_axis_aclk),
    .m00_axis_aresetn(m00_axis_aresetn),
    .m00_axis_tvalid (m00_axis_tvalid),
    .m00_axis_tdata  (m00_axis_tdata),
    .m00_axis_tkeep  (m00_axis_tkeep),
    .m00_axis_tlast  (m00_axis_tlast),
    .m00_axis_tready (m00_axis_tready)
);

//--- test/udp_cases.txt
# op addr data (hex): W write, R read and compare, C capture one frame, I idle cycles in data
# Addresses are in wire order, first byte in bits 7:0
R 08 000000C8
R 0C FFFFFFFF
R 10 0000FFFF
R 14 6304A8C0
R 18 0104A8C0
R 00 00000000
C 00 00000000
W 08 00000000
W 0C 44332211
W 10 0000BBAA
W 14 0A00000A
W 18 FF01A8C0
R 0C 44332211
R 10 0000BBAA
R 14 0A00000A
R 18 FF01A8C0
R 1C 00000000
W 08 000000C8
C 00 00000000
C 00 00000000
W 08 00000000
R 00 00000003
I 00 00000258
